//--- include/decode_consts.svh
//################################################
// decode stage constants
// datapath widths and register file sizing
//################################################

`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`default_nettype none

`define DATA_W      32  // data and instruction width
`define REG_ADDR_W  5
`define REG_COUNT   32
`define LINK_REG    31  // highest register number

`default_nettype wire

`endif

//--- logic/mipsIsaPkg.sv
//################################################
// MIPS instruction set encodings
// primary opcodes and R-type function codes of
// the decoded subset
//################################################

`default_nettype none

package mipsIsaPkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, see funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    // function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } functE;

endpackage

`default_nettype wire

//--- logic/decodeCtrlPkg.sv
//################################################
// decode control encodings
// ALU operation, immediate extension and
// destination register select
//################################################

`default_nettype none

package decodeCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_NOP  // no ALU result needed
    } aluOpE;

    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO,
        EXT_UPPER  // imm16 into the upper half
    } extOpE;

    // which instruction field names the destination
    typedef enum logic [1:0] {
        DST_NONE,
        DST_RD,
        DST_RT
    } dstSelE;

endpackage

`default_nettype wire

//--- logic/fetchDecodeReg.sv
//################################################
// IF/ID pipeline register
// holds instruction, PC and valid from fetch;
// hold freezes it, flush turns the slot to a no-op
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module fetchDecodeReg (
    input  logic              clk,
    input  logic              arstN,
    input  logic              flush,
    input  logic              hold,        // stall or EXE back-pressure
    input  logic [`DATA_W-1:0] fetchInstr,
    input  logic [`DATA_W-1:0] fetchPc,
    input  logic              fetchValid,
    output logic [`DATA_W-1:0] idInstr,
    output logic [`DATA_W-1:0] idPc,
    output logic              idValid
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idValid <= 1'b0;
            idInstr <= '0;
        end else if (flush) begin
            // all-zero word decodes as SLL r0, a no-op
            idValid <= 1'b0;
            idInstr <= '0;
        end else if (!hold) begin
            idValid <= fetchValid;
            idInstr <= fetchInstr;
        end
    end

    // pc is payload only
    always_ff @(posedge clk) begin
        if (!hold) idPc <= fetchPc;
    end

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
//################################################
// instruction decoder
// turns opcode and funct into ALU op, immediate,
// destination and register-use flags
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module instrDecoder (
    input  logic [`DATA_W-1:0]     idInstr,
    output decodeCtrlPkg::aluOpE   aluOp,
    output logic [`DATA_W-1:0]     imm32,
    output logic [`REG_ADDR_W-1:0] dst,
    output logic                   readsRs,
    output logic                   readsRt,
    output logic                   regWrite,
    output logic                   isLoad,
    output logic                   isStore,
    output logic                   isBranch,
    output logic                   isJump,
    output logic                   illegal
);
    mipsIsaPkg::opcodeE    opcode;
    mipsIsaPkg::functE     funct;
    decodeCtrlPkg::extOpE  extOp;
    decodeCtrlPkg::dstSelE dstSel;
    logic [15:0]           imm16;

    assign opcode = mipsIsaPkg::opcodeE'(idInstr[31:26]);
    assign funct  = mipsIsaPkg::functE'(idInstr[5:0]);
    assign imm16  = idInstr[15:0];

    always_comb begin
        aluOp    = decodeCtrlPkg::ALU_NOP;
        extOp    = decodeCtrlPkg::EXT_SIGN;
        dstSel   = decodeCtrlPkg::DST_NONE;
        readsRs  = 1'b1;  // most instructions read rs
        readsRt  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            mipsIsaPkg::OP_SPECIAL: begin
                readsRt = 1'b1;
                dstSel  = decodeCtrlPkg::DST_RD;
                case (funct)
                    mipsIsaPkg::FN_ADDU: aluOp = decodeCtrlPkg::ALU_ADD;
                    mipsIsaPkg::FN_SUBU: aluOp = decodeCtrlPkg::ALU_SUB;
                    mipsIsaPkg::FN_AND:  aluOp = decodeCtrlPkg::ALU_AND;
                    mipsIsaPkg::FN_OR:   aluOp = decodeCtrlPkg::ALU_OR;
                    mipsIsaPkg::FN_XOR:  aluOp = decodeCtrlPkg::ALU_XOR;
                    mipsIsaPkg::FN_SLT:  aluOp = decodeCtrlPkg::ALU_SLT;
                    mipsIsaPkg::FN_SLL: begin
                        aluOp   = decodeCtrlPkg::ALU_SLL;
                        readsRs = 1'b0;  // shifts rt by shamt
                    end
                    mipsIsaPkg::FN_JR: begin
                        dstSel = decodeCtrlPkg::DST_NONE;
                        isJump = 1'b1;
                    end
                    default: begin
                        dstSel  = decodeCtrlPkg::DST_NONE;
                        illegal = 1'b1;
                    end
                endcase
            end
            mipsIsaPkg::OP_ADDIU: begin
                aluOp  = decodeCtrlPkg::ALU_ADD;
                dstSel = decodeCtrlPkg::DST_RT;
            end
            mipsIsaPkg::OP_ANDI: begin
                aluOp  = decodeCtrlPkg::ALU_AND;
                extOp  = decodeCtrlPkg::EXT_ZERO;
                dstSel = decodeCtrlPkg::DST_RT;
            end
            mipsIsaPkg::OP_ORI: begin
                aluOp  = decodeCtrlPkg::ALU_OR;
                extOp  = decodeCtrlPkg::EXT_ZERO;
                dstSel = decodeCtrlPkg::DST_RT;
            end
            mipsIsaPkg::OP_LUI: begin
                aluOp   = decodeCtrlPkg::ALU_LUI;
                extOp   = decodeCtrlPkg::EXT_UPPER;
                dstSel  = decodeCtrlPkg::DST_RT;
                readsRs = 1'b0;
            end
            mipsIsaPkg::OP_LW: begin
                aluOp  = decodeCtrlPkg::ALU_ADD;  // address calc
                dstSel = decodeCtrlPkg::DST_RT;
                isLoad = 1'b1;
            end
            mipsIsaPkg::OP_SW: begin
                aluOp   = decodeCtrlPkg::ALU_ADD;
                readsRt = 1'b1;  // store data
                isStore = 1'b1;
            end
            mipsIsaPkg::OP_BEQ: begin
                aluOp    = decodeCtrlPkg::ALU_SUB;  // compare by subtract
                readsRt  = 1'b1;
                isBranch = 1'b1;
            end
            mipsIsaPkg::OP_J: begin
                readsRs = 1'b0;
                isJump  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (extOp)
            decodeCtrlPkg::EXT_ZERO:  imm32 = {{(`DATA_W-16){1'b0}}, imm16};
            decodeCtrlPkg::EXT_UPPER: imm32 = {imm16, {(`DATA_W-16){1'b0}}};
            default:                  imm32 = {{(`DATA_W-16){imm16[15]}}, imm16};
        endcase
    end

    always_comb begin
        case (dstSel)
            decodeCtrlPkg::DST_RD: dst = idInstr[15:11];
            decodeCtrlPkg::DST_RT: dst = idInstr[20:16];
            default:               dst = '0;
        endcase
    end

    assign regWrite = (dstSel != decodeCtrlPkg::DST_NONE);

endmodule

`default_nettype wire

//--- logic/regFile.sv
//################################################
// register file, 32 x 32
// one write port, two read ports, r0 reads zero,
// write-back data bypassed onto the read ports
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   wbWe,
    input  logic [`REG_ADDR_W-1:0] wbDst,
    input  logic [`DATA_W-1:0]     wbData,
    input  logic [`REG_ADDR_W-1:0] rsAddr,
    input  logic [`REG_ADDR_W-1:0] rtAddr,
    output logic [`DATA_W-1:0]     busA,
    output logic [`DATA_W-1:0]     busB
);
    logic [`DATA_W-1:0] regs [1:`REG_COUNT-1];  // no storage for r0
    logic               wbLive;

    assign wbLive = wbWe && (wbDst != '0);

    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;
        if (wbLive && (wbDst == addr)) return wbData;  // same-cycle write
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i <= `LINK_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (wbLive) begin
            regs[wbDst] <= wbData;
        end
    end

    assign busA = readPort(rsAddr);
    assign busB = readPort(rtAddr);

endmodule

`default_nettype wire

//--- logic/decodeExecReg.sv
//################################################
// ID/EXE pipeline register
// joins decoder controls with register operands,
// stalls on a load-use hazard and inserts a bubble
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module decodeExecReg (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   exeHold,
    input  logic                   idValid,
    input  logic [`DATA_W-1:0]     idPc,
    input  logic [`REG_ADDR_W-1:0] idRs,
    input  logic [`REG_ADDR_W-1:0] idRt,
    input  decodeCtrlPkg::aluOpE   aluOp,
    input  logic [`DATA_W-1:0]     imm32,
    input  logic [`REG_ADDR_W-1:0] dst,
    input  logic                   readsRs,
    input  logic                   readsRt,
    input  logic                   regWrite,
    input  logic                   isLoad,
    input  logic                   isStore,
    input  logic                   isBranch,
    input  logic                   isJump,
    input  logic                   illegal,
    input  logic [`DATA_W-1:0]     busA,
    input  logic [`DATA_W-1:0]     busB,
    output logic                   stall,
    output logic                   exeValid,
    output logic [`DATA_W-1:0]     exePc,
    output decodeCtrlPkg::aluOpE   exeAluOp,
    output logic [`DATA_W-1:0]     exeImm,
    output logic [`DATA_W-1:0]     exeBusA,
    output logic [`DATA_W-1:0]     exeBusB,
    output logic [`REG_ADDR_W-1:0] exeRs,
    output logic [`REG_ADDR_W-1:0] exeRt,
    output logic [`REG_ADDR_W-1:0] exeDst,
    output logic                   exeRegWrite,
    output logic                   exeIsLoad,
    output logic                   exeIsStore,
    output logic                   exeIsBranch,
    output logic                   exeIsJump,
    output logic                   exeIllegal
);
    logic loadPending;  // held entry is a load with a real target

    assign loadPending = exeValid && exeIsLoad && (exeRt != '0);
    assign stall = idValid && loadPending &&
                   ((readsRs && (exeRt == idRs)) || (readsRt && (exeRt == idRt)));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeValid    <= 1'b0;
            exeAluOp    <= decodeCtrlPkg::ALU_NOP;
            exeRegWrite <= 1'b0;
            exeIsLoad   <= 1'b0;
            exeIsStore  <= 1'b0;
            exeIsBranch <= 1'b0;
            exeIsJump   <= 1'b0;
            exeIllegal  <= 1'b0;
        end else if (!exeHold) begin
            // bubble under stall, otherwise flags qualified by valid
            exeValid    <= idValid && !stall;
            exeAluOp    <= stall ? decodeCtrlPkg::ALU_NOP : aluOp;
            exeRegWrite <= idValid && !stall && regWrite;
            exeIsLoad   <= idValid && !stall && isLoad;
            exeIsStore  <= idValid && !stall && isStore;
            exeIsBranch <= idValid && !stall && isBranch;
            exeIsJump   <= idValid && !stall && isJump;
            exeIllegal  <= idValid && !stall && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (!exeHold) begin
            exePc   <= idPc;
            exeImm  <= imm32;
            exeBusA <= busA;
            exeBusB <= busB;
            exeRs   <= idRs;
            exeRt   <= idRt;
            exeDst  <= dst;
        end
    end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
//################################################
// instruction decode stage
// IF/ID register, decoder, register file and
// ID/EXE register with load-use stall
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module decodeStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`DATA_W-1:0]     fetchInstr,
    input  logic [`DATA_W-1:0]     fetchPc,
    input  logic                   fetchValid,
    input  logic                   flush,       // from branch resolution
    input  logic                   exeHold,
    input  logic                   wbWe,
    input  logic [`REG_ADDR_W-1:0] wbDst,
    input  logic [`DATA_W-1:0]     wbData,
    output logic                   stall,
    output logic                   exeValid,
    output logic [`DATA_W-1:0]     exePc,
    output decodeCtrlPkg::aluOpE   exeAluOp,
    output logic [`DATA_W-1:0]     exeImm,
    output logic [`DATA_W-1:0]     exeBusA,
    output logic [`DATA_W-1:0]     exeBusB,
    output logic [`REG_ADDR_W-1:0] exeRs,
    output logic [`REG_ADDR_W-1:0] exeRt,
    output logic [`REG_ADDR_W-1:0] exeDst,
    output logic                   exeRegWrite,
    output logic                   exeIsLoad,
    output logic                   exeIsStore,
    output logic                   exeIsBranch,
    output logic                   exeIsJump,
    output logic                   exeIllegal
);
    logic [`DATA_W-1:0]     idInstr;
    logic [`DATA_W-1:0]     idPc;
    logic                   idValid;
    logic                   hold;
    logic [`REG_ADDR_W-1:0] idRs;
    logic [`REG_ADDR_W-1:0] idRt;
    decodeCtrlPkg::aluOpE   idAluOp;
    logic [`DATA_W-1:0]     idImm;
    logic [`REG_ADDR_W-1:0] idDst;
    logic                   idReadsRs;
    logic                   idReadsRt;
    logic                   idRegWrite;
    logic                   idIsLoad;
    logic                   idIsStore;
    logic                   idIsBranch;
    logic                   idIsJump;
    logic                   idIllegal;
    logic [`DATA_W-1:0]     busA;
    logic [`DATA_W-1:0]     busB;

    assign hold = stall || exeHold;
    assign idRs = idInstr[25:21];
    assign idRt = idInstr[20:16];

    fetchDecodeReg uFetchDecodeReg (
        .clk        (clk),
        .arstN      (arstN),
        .flush      (flush),
        .hold       (hold),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid),
        .idInstr    (idInstr),
        .idPc       (idPc),
        .idValid    (idValid)
    );

    instrDecoder uInstrDecoder (
        .idInstr  (idInstr),
        .aluOp    (idAluOp),
        .imm32    (idImm),
        .dst      (idDst),
        .readsRs  (idReadsRs),
        .readsRt  (idReadsRt),
        .regWrite (idRegWrite),
        .isLoad   (idIsLoad),
        .isStore  (idIsStore),
        .isBranch (idIsBranch),
        .isJump   (idIsJump),
        .illegal  (idIllegal)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .wbWe   (wbWe),
        .wbDst  (wbDst),
        .wbData (wbData),
        .rsAddr (idRs),
        .rtAddr (idRt),
        .busA   (busA),
        .busB   (busB)
    );

    decodeExecReg uDecodeExecReg (
        .clk         (clk),
        .arstN       (arstN),
        .exeHold     (exeHold),
        .idValid     (idValid),
        .idPc        (idPc),
        .idRs        (idRs),
        .idRt        (idRt),
        .aluOp       (idAluOp),
        .imm32       (idImm),
        .dst         (idDst),
        .readsRs     (idReadsRs),
        .readsRt     (idReadsRt),
        .regWrite    (idRegWrite),
        .isLoad      (idIsLoad),
        .isStore     (idIsStore),
        .isBranch    (idIsBranch),
        .isJump      (idIsJump),
        .illegal     (idIllegal),
        .busA        (busA),
        .busB        (busB),
        .stall       (stall),
        .exeValid    (exeValid),
        .exePc       (exePc),
        .exeAluOp    (exeAluOp),
        .exeImm      (exeImm),
        .exeBusA     (exeBusA),
        .exeBusB     (exeBusB),
        .exeRs       (exeRs),
        .exeRt       (exeRt),
        .exeDst      (exeDst),
        .exeRegWrite (exeRegWrite),
        .exeIsLoad   (exeIsLoad),
        .exeIsStore  (exeIsStore),
        .exeIsBranch (exeIsBranch),
        .exeIsJump   (exeIsJump),
        .exeIllegal  (exeIllegal)
    );

endmodule

`default_nettype wire

//--- test/decodeStage_chk.sv
//################################################
// decode stage assertion checker
// stall cause, bubble, reset and r0 rules
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module decodeStage_chk (
    input logic                   clk,
    input logic                   arstN,
    input logic                   stall,
    input logic                   exeHold,
    input logic                   idValid,
    input logic [`DATA_W-1:0]     idInstr,
    input logic [`REG_ADDR_W-1:0] idRs,
    input logic [`REG_ADDR_W-1:0] idRt,
    input logic [`DATA_W-1:0]     busA,
    input logic [`DATA_W-1:0]     busB,
    input logic                   exeValid,
    input logic [`REG_ADDR_W-1:0] exeRt,
    input logic                   exeRegWrite,
    input logic                   exeIsLoad,
    input logic                   exeIsStore,
    input logic                   exeIsBranch,
    input logic                   exeIsJump,
    input logic                   exeIllegal
);
    int         failCount = 0;
    logic [5:0] opField;
    logic [5:0] fnField;
    logic       isSll;
    logic       usesRs;  // source use taken from the ISA, not the decoder
    logic       usesRt;

    assign opField = idInstr[31:26];
    assign fnField = idInstr[5:0];
    assign isSll   = (opField == mipsIsaPkg::OP_SPECIAL) && (fnField == mipsIsaPkg::FN_SLL);
    assign usesRs  = !(isSll || (opField == mipsIsaPkg::OP_LUI) ||
                       (opField == mipsIsaPkg::OP_J));
    assign usesRt  = (opField == mipsIsaPkg::OP_SPECIAL) || (opField == mipsIsaPkg::OP_SW) ||
                     (opField == mipsIsaPkg::OP_BEQ);

    // a stall needs a valid load in EXE whose rt feeds a used source
    stallCause: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> idValid && exeValid && exeIsLoad && (exeRt != '0) &&
                  ((usesRs && (exeRt == idRs)) || (usesRt && (exeRt == idRt))))
    else begin
        $error("stall raised without a matching load in EXE");
        failCount++;
    end

    stallBubble: assert property (@(posedge clk) disable iff (!arstN)
        stall && !exeHold |=> !exeValid)  // bubble follows
    else begin
        $error("no bubble in EXE after a stall");
        failCount++;
    end

    resetFlags: assert property (@(posedge clk)
        !arstN |-> !(exeValid || exeRegWrite || exeIsLoad || exeIsStore ||
                     exeIsBranch || exeIsJump || exeIllegal || stall))
    else begin
        $error("EXE control flags high during reset");
        failCount++;
    end

    zeroReg: assert property (@(posedge clk) disable iff (!arstN)
        ((idRs != '0) || (busA == '0)) && ((idRt != '0) || (busB == '0)))
    else begin
        $error("register 0 read back nonzero");
        failCount++;
    end

endmodule

bind decodeStage decodeStage_chk uChk (
    .clk         (clk),
    .arstN       (arstN),
    .stall       (stall),
    .exeHold     (exeHold),
    .idValid     (idValid),
    .idInstr     (idInstr),
    .idRs        (idRs),
    .idRt        (idRt),
    .busA        (busA),
    .busB        (busB),
    .exeValid    (exeValid),
    .exeRt       (exeRt),
    .exeRegWrite (exeRegWrite),
    .exeIsLoad   (exeIsLoad),
    .exeIsStore  (exeIsStore),
    .exeIsBranch (exeIsBranch),
    .exeIsJump   (exeIsJump),
    .exeIllegal  (exeIllegal)
);

`default_nettype wire

//--- test/decodeStage_tb.sv
//################################################
// decode stage testbench
// register writes and reads, bypass, decode table,
// load-use stall, EXE hold and flush
//################################################

`include "decode_consts.svh"

`default_nettype none
`timescale 1ns/10ps

module decodeStage_tb;

    logic                   clk;
    logic                   arstN;
    logic [`DATA_W-1:0]     fetchInstr;
    logic [`DATA_W-1:0]     fetchPc;
    logic                   fetchValid;
    logic                   flush;
    logic                   exeHold;
    logic                   wbWe;
    logic [`REG_ADDR_W-1:0] wbDst;
    logic [`DATA_W-1:0]     wbData;
    logic                   stall;
    logic                   exeValid;
    logic [`DATA_W-1:0]     exePc;
    decodeCtrlPkg::aluOpE   exeAluOp;
    logic [`DATA_W-1:0]     exeImm;
    logic [`DATA_W-1:0]     exeBusA;
    logic [`DATA_W-1:0]     exeBusB;
    logic [`REG_ADDR_W-1:0] exeRs;
    logic [`REG_ADDR_W-1:0] exeRt;
    logic [`REG_ADDR_W-1:0] exeDst;
    logic                   exeRegWrite;
    logic                   exeIsLoad;
    logic                   exeIsStore;
    logic                   exeIsBranch;
    logic                   exeIsJump;
    logic                   exeIllegal;

    logic [`DATA_W-1:0] regModel [0:`REG_COUNT-1];  // expected register contents
    logic [31:0]        lcgState;
    logic [`DATA_W-1:0] pcNext;
    logic [`DATA_W-1:0] lastPc;                     // pc of the latest fetch
    int                 errors;

    decodeStage UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input mipsIsaPkg::functE fn);
        return {mipsIsaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input mipsIsaPkg::opcodeE op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic expectEq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // called at a rising edge, no wait inside
    task automatic present(input logic [`DATA_W-1:0] instr);
        fetchInstr <= instr;
        fetchPc    <= pcNext;
        fetchValid <= 1'b1;
        lastPc = pcNext;
        pcNext = pcNext + 32'd4;
    endtask

    // leaves the instruction sitting in IF/ID
    task automatic issue(input logic [`DATA_W-1:0] instr);
        @(posedge clk);
        present(instr);
        @(posedge clk);
        fetchValid <= 1'b0;
        fetchInstr <= '0;
    endtask

    task automatic waitExe(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!exeValid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!exeValid) begin
            $display("timeout in %s: no valid instruction reached the EXE outputs", name);
            errors++;
        end
    endtask

    task automatic writeReg(input logic [4:0] dst, input logic [31:0] data);
        @(posedge clk);
        wbWe   <= 1'b1;
        wbDst  <= dst;
        wbData <= data;
        if (dst != '0) regModel[dst] = data;  // r0 ignores writes
    endtask

    // flags are {regWrite, isLoad, isStore, isBranch, isJump, illegal}
    task automatic runDecode(input string name, input logic [31:0] instr,
                             input decodeCtrlPkg::aluOpE expAlu, input logic immKnown,
                             input logic [31:0] expImm, input logic [4:0] expDst,
                             input logic [5:0] expFlags);
        issue(instr);
        waitExe(name);
        expectEq({name, " aluOp"}, 32'(expAlu), 32'(exeAluOp));
        if (immKnown) expectEq({name, " imm"}, expImm, exeImm);
        if (expFlags[5]) expectEq({name, " dst"}, 32'(expDst), 32'(exeDst));
        expectEq({name, " flags"}, 32'(expFlags), 32'({exeRegWrite, exeIsLoad, exeIsStore,
                                                       exeIsBranch, exeIsJump, exeIllegal}));
        expectEq({name, " rs"}, 32'(instr[25:21]), 32'(exeRs));
        expectEq({name, " rt"}, 32'(instr[20:16]), 32'(exeRt));
        expectEq({name, " pc"}, lastPc, exePc);
    endtask

    initial begin
        logic [15:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] val;
        logic [31:0] pcSent;
        int          n;
        clk = 1'b0;
        arstN      <= 1'b0;
        fetchInstr <= '0;
        fetchPc    <= '0;
        fetchValid <= 1'b0;
        flush      <= 1'b0;
        exeHold    <= 1'b0;
        wbWe       <= 1'b0;
        wbDst      <= '0;
        wbData     <= '0;
        lcgState = 32'h2b95;
        pcNext   = 32'h0000_0400;
        lastPc   = '0;
        errors   = 0;
        for (int i = 0; i < `REG_COUNT; i++) regModel[i] = '0;

        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        expectEq("reset flags", 32'd0, 32'({stall, exeValid, exeRegWrite, exeIsLoad,
                                            exeIsStore, exeIsBranch, exeIsJump, exeIllegal}));

        // fill r1..r31, then try r0
        for (int r = 1; r < `REG_COUNT; r++) writeReg(5'(r), nextRand());
        writeReg(5'd0, nextRand());
        @(posedge clk);
        wbWe <= 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            rs = 5'(r);
            rt = 5'(`LINK_REG - r);
            issue(rType(rs, rt, 5'd1, mipsIsaPkg::FN_ADDU));
            waitExe("regRead");
            expectEq("regRead busA", regModel[rs], exeBusA);
            expectEq("regRead busB", regModel[rt], exeBusB);
        end

        // write lands in the same cycle the read happens
        rs  = 5'd9;
        val = nextRand();
        issue(rType(rs, rs, 5'd2, mipsIsaPkg::FN_OR));
        wbWe   <= 1'b1;
        wbDst  <= rs;
        wbData <= val;
        regModel[rs] = val;
        @(posedge clk);
        wbWe <= 1'b0;
        waitExe("bypass");
        expectEq("bypass busA", val, exeBusA);
        expectEq("bypass busB", val, exeBusB);

        imm = 16'(nextRand() >> 8);
        rs  = 5'(nextRand() >> 11);
        rt  = 5'(nextRand() >> 13);
        rd  = 5'(nextRand() >> 17);
        runDecode("addu", rType(rs, rt, rd, mipsIsaPkg::FN_ADDU), decodeCtrlPkg::ALU_ADD,
                  1'b0, '0, rd, 6'b100000);
        runDecode("subu", rType(rs, rt, rd, mipsIsaPkg::FN_SUBU), decodeCtrlPkg::ALU_SUB,
                  1'b0, '0, rd, 6'b100000);
        runDecode("and", rType(rs, rt, rd, mipsIsaPkg::FN_AND), decodeCtrlPkg::ALU_AND,
                  1'b0, '0, rd, 6'b100000);
        runDecode("or", rType(rs, rt, rd, mipsIsaPkg::FN_OR), decodeCtrlPkg::ALU_OR,
                  1'b0, '0, rd, 6'b100000);
        runDecode("xor", rType(rs, rt, rd, mipsIsaPkg::FN_XOR), decodeCtrlPkg::ALU_XOR,
                  1'b0, '0, rd, 6'b100000);
        runDecode("slt", rType(rs, rt, rd, mipsIsaPkg::FN_SLT), decodeCtrlPkg::ALU_SLT,
                  1'b0, '0, rd, 6'b100000);
        runDecode("sll", rType(5'd0, rt, rd, mipsIsaPkg::FN_SLL), decodeCtrlPkg::ALU_SLL,
                  1'b0, '0, rd, 6'b100000);
        runDecode("jr", rType(rs, 5'd0, 5'd0, mipsIsaPkg::FN_JR), decodeCtrlPkg::ALU_NOP,
                  1'b0, '0, '0, 6'b000010);
        runDecode("addiu", iType(mipsIsaPkg::OP_ADDIU, rs, rt, imm), decodeCtrlPkg::ALU_ADD,
                  1'b1, {{16{imm[15]}}, imm}, rt, 6'b100000);
        runDecode("andi", iType(mipsIsaPkg::OP_ANDI, rs, rt, imm), decodeCtrlPkg::ALU_AND,
                  1'b1, {16'd0, imm}, rt, 6'b100000);
        runDecode("ori", iType(mipsIsaPkg::OP_ORI, rs, rt, imm), decodeCtrlPkg::ALU_OR,
                  1'b1, {16'd0, imm}, rt, 6'b100000);
        runDecode("lui", iType(mipsIsaPkg::OP_LUI, 5'd0, rt, imm), decodeCtrlPkg::ALU_LUI,
                  1'b1, {imm, 16'd0}, rt, 6'b100000);
        runDecode("lw", iType(mipsIsaPkg::OP_LW, rs, rt, imm), decodeCtrlPkg::ALU_ADD,
                  1'b1, {{16{imm[15]}}, imm}, rt, 6'b110000);
        runDecode("sw", iType(mipsIsaPkg::OP_SW, rs, rt, imm), decodeCtrlPkg::ALU_ADD,
                  1'b1, {{16{imm[15]}}, imm}, '0, 6'b001000);
        runDecode("beq", iType(mipsIsaPkg::OP_BEQ, rs, rt, imm), decodeCtrlPkg::ALU_SUB,
                  1'b1, {{16{imm[15]}}, imm}, '0, 6'b000100);
        runDecode("j", {mipsIsaPkg::OP_J, 26'(nextRand())}, decodeCtrlPkg::ALU_NOP,
                  1'b0, '0, '0, 6'b000010);
        runDecode("undefined", {6'h3f, 26'(nextRand())}, decodeCtrlPkg::ALU_NOP,
                  1'b0, '0, '0, 6'b000001);

        // LW r5 then ADDU reading r5, back to back
        @(posedge clk);
        present(iType(mipsIsaPkg::OP_LW, 5'd4, 5'd5, 16'h0010));
        @(posedge clk);
        present(rType(5'd5, 5'd3, 5'd7, mipsIsaPkg::FN_ADDU));
        pcSent = lastPc;
        @(posedge clk);
        fetchValid <= 1'b0;
        fetchInstr <= '0;
        @(negedge clk);
        expectEq("loadUse stall", 32'd1, 32'({stall, exeIsLoad} == 2'b11));
        @(negedge clk);
        expectEq("loadUse bubble", 32'd0, 32'({stall, exeValid}));
        waitExe("loadUse");
        expectEq("loadUse aluOp", 32'(decodeCtrlPkg::ALU_ADD), 32'(exeAluOp));
        expectEq("loadUse pc", pcSent, exePc);
        expectEq("loadUse busA", regModel[5], exeBusA);

        // EXE back-pressure freezes both registers
        issue(iType(mipsIsaPkg::OP_ORI, 5'd3, 5'd8, imm));
        pcSent = lastPc;
        @(posedge clk);
        exeHold <= 1'b1;
        present(iType(mipsIsaPkg::OP_ADDIU, 5'd1, 5'd9, imm));
        for (n = 0; n < 3; n++) begin
            @(negedge clk);
            expectEq("hold exeValid", 32'd1, 32'(exeValid));
            expectEq("hold aluOp", 32'(decodeCtrlPkg::ALU_OR), 32'(exeAluOp));
            expectEq("hold pc", pcSent, exePc);
        end
        @(posedge clk);
        exeHold <= 1'b0;
        @(posedge clk);
        fetchValid <= 1'b0;  // ADDIU taken at this edge
        fetchInstr <= '0;
        waitExe("holdRelease");
        expectEq("holdRelease aluOp", 32'(decodeCtrlPkg::ALU_ADD), 32'(exeAluOp));
        expectEq("holdRelease pc", lastPc, exePc);

        // flush the ADDU while it waits behind a load
        @(posedge clk);
        present(iType(mipsIsaPkg::OP_LW, 5'd4, 5'd6, 16'h0020));
        @(posedge clk);
        present(rType(5'd6, 5'd2, 5'd10, mipsIsaPkg::FN_ADDU));
        @(posedge clk);
        fetchValid <= 1'b0;
        fetchInstr <= '0;
        flush      <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            expectEq("flush exeValid", 32'd0, 32'(exeValid));
        end

        @(negedge clk);
        $display("errors: %0d check failures, %0d assertion failures",
                 errors, UUT.uChk.failCount);
        if (errors == 0 && UUT.uChk.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
logic/mipsIsaPkg.sv
logic/decodeCtrlPkg.sv
logic/fetchDecodeReg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/decodeExecReg.sv
logic/decodeStage.sv
test/decodeStage_chk.sv
test/decodeStage_tb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench
TOP = decodeStage_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
